// File: decode_stage.f
+incdir+src
src/decode_pkg.sv
src/reg_file.sv
src/control_unit.sv
src/branch_unit.sv
src/decode_stage.sv
sim/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with verilator, run it, then check the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f decode_stage.f --top-module decode_tb -o decode_sim > build.log 2>&1 &&
./obj_dir/decode_sim > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "sim passed" sim.log && exit 0 || { cat sim.log; exit 1; }

// File: sim/decode_tb.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_tb;

  // ##################################################
  // run length in cycles
  // ##################################################
  localparam int REG_TEST    = 2 * `REG_CNT + `REG_CNT * `REG_CNT + 1;
  localparam int TEST_CYCLES = 3 + REG_TEST + 22 + 33 +
                               `RET_CYCLES + `RTI_CYCLES + `INT_CYCLES + 8 + 5;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic                  clk;
  logic                  rst_n;
  logic [`DATA_W-1:0]    instr;
  decode_pkg::wb_t       wb;
  logic                  load_use;
  logic                  interrupt;
  logic [2:0]            ccr;          // {c, n, z}
  decode_pkg::ctrl_t     ctrl;
  logic                  branch;
  logic                  branch_taken;
  decode_pkg::pc_sel_e   pc_sel;
  logic [`PC_W-1:0]      pc_jmp;
  logic [`DATA_W-1:0]    op1;
  logic [`DATA_W-1:0]    r_op2;
  logic [`DATA_W-1:0]    i_op2;
  logic [7:0]            shift_amount;
  decode_pkg::reg_addr_t rdst_addr;
  decode_pkg::reg_addr_t rsrc_addr;
  logic                  freeze;
  logic                  fetch_pc_enable;
  logic [13:0]           strobes;      // every write enable and strobe in ctrl
  logic [`DATA_W-1:0]    regs_m [`REG_CNT];
  logic [31:0]           seed;
  int                    cycle_cnt = 0;
  int                    checks;
  int                    errors;

  decode_stage i_decode_stage (.*);

  assign strobes = {ctrl.reg_wr, ctrl.mem_rd, ctrl.mem_wr, ctrl.mem_to_reg, ctrl.ldm,
                    ctrl.stack, ctrl.port_rd, ctrl.port_wr, ctrl.call, ctrl.ret,
                    ctrl.rti, ctrl.pop_pc1, ctrl.pop_pc2, ctrl.pop_ccr};

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  bubble_strobes: assert property (@(posedge clk) disable iff (!rst_n)
    load_use |-> (strobes == '0))
    else begin
      errors++;
      $display("Fail strobes: expected 0000 while load_use is high, got %h", strobes);
    end

  fetch_gate: assert property (@(posedge clk) disable iff (!rst_n)
    load_use |-> !fetch_pc_enable)
    else begin
      errors++;
      $display("fetch_pc_enable stayed high during a load-use bubble");
    end

  function automatic logic [15:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[31:16];
  endfunction

  function automatic logic [15:0] reg_instr(input decode_pkg::opcode_e op,
                                            input logic [2:0] rs, input logic [2:0] rd);
    return {op, rs, rd, 5'b0};
  endfunction

  // ##################################################
  // reference decode table
  // ##################################################
  function automatic decode_pkg::ctrl_t expected_ctrl(input decode_pkg::opcode_e op);
    decode_pkg::ctrl_t c;
    logic [17:0]       row;   // alu_op, alu_src, wr rd wm m2r ldm stk prd pwr, call ret rti
    c = '0;
    case (op)
      decode_pkg::OP_ADD:  row = {decode_pkg::ALU_ADD, 2'b00, 11'b1000_0000_000};
      decode_pkg::OP_SUB:  row = {decode_pkg::ALU_SUB, 2'b00, 11'b1000_0000_000};
      decode_pkg::OP_AND:  row = {decode_pkg::ALU_AND, 2'b00, 11'b1000_0000_000};
      decode_pkg::OP_OR:   row = {decode_pkg::ALU_OR, 2'b00, 11'b1000_0000_000};
      decode_pkg::OP_NOT:  row = {decode_pkg::ALU_NOT, 2'b01, 11'b1000_0000_000};
      decode_pkg::OP_INC:  row = {decode_pkg::ALU_INC, 2'b01, 11'b1000_0000_000};
      decode_pkg::OP_SHL:  row = {decode_pkg::ALU_SHL, 2'b11, 11'b1000_0000_000};
      decode_pkg::OP_SHR:  row = {decode_pkg::ALU_SHR, 2'b11, 11'b1000_0000_000};
      decode_pkg::OP_LDM:  row = {decode_pkg::ALU_PASS, 2'b11, 11'b1000_1000_000};
      decode_pkg::OP_LDD:  row = {decode_pkg::ALU_PASS, 2'b00, 11'b1101_0000_000};
      decode_pkg::OP_STD:  row = {decode_pkg::ALU_PASS, 2'b00, 11'b0010_0000_000};
      decode_pkg::OP_PUSH: row = {decode_pkg::ALU_PASS, 2'b01, 11'b0010_0100_000};
      decode_pkg::OP_POP:  row = {decode_pkg::ALU_PASS, 2'b01, 11'b1101_0100_000};
      decode_pkg::OP_IN:   row = {decode_pkg::ALU_PASS, 2'b01, 11'b1000_0010_000};
      decode_pkg::OP_OUT:  row = {decode_pkg::ALU_PASS, 2'b01, 11'b0000_0001_000};
      decode_pkg::OP_CALL: row = {decode_pkg::ALU_PASS, 2'b00, 11'b0010_0100_100};
      decode_pkg::OP_RET:  row = {decode_pkg::ALU_PASS, 2'b00, 11'b0000_0000_010};
      decode_pkg::OP_RTI:  row = {decode_pkg::ALU_PASS, 2'b00, 11'b0000_0000_001};
      default:             row = '0;   // nop and the jumps
    endcase
    {c.alu_op, c.alu_src, c.reg_wr, c.mem_rd, c.mem_wr, c.mem_to_reg, c.ldm, c.stack,
     c.port_rd, c.port_wr, c.call, c.ret, c.rti} = row;
    c.mem_data_sel = (op == decode_pkg::OP_CALL) ? decode_pkg::MEM_PC : decode_pkg::MEM_REG;
    return c;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report(input string name, input int err_start);
    if (errors == err_start) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_start);
    end
  endtask

  initial begin
    int                  err_start;
    int                  len;
    logic [15:0]         word;
    logic                exp_taken;
    decode_pkg::ctrl_t   exp;
    decode_pkg::opcode_e op;
    decode_pkg::pc_sel_e exp_sel;
    clk       = 1'b0;
    rst_n     = 1'b0;
    instr     = '0;
    wb        = '0;
    load_use  = 1'b0;
    interrupt = 1'b0;
    ccr       = '0;
    seed      = 32'd67;
    checks    = 0;
    errors    = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // ##################################################
    // register writeback and read
    // ##################################################
    err_start = errors;
    for (int r = 0; r < `REG_CNT; r++) begin
      next_cycle();
      wb.wr_en  = 1'b1;
      wb.addr   = 3'(r);
      wb.data   = lcg_next();
      regs_m[r] = wb.data;
    end
    next_cycle();
    wb.wr_en = 1'b0;
    for (int s = 0; s < `REG_CNT; s++) begin
      for (int d = 0; d < `REG_CNT; d++) begin
        next_cycle();
        instr = reg_instr(decode_pkg::OP_ADD, 3'(s), 3'(d));
        #1;
        check_val("op1", 32'(regs_m[s]), 32'(op1));
        check_val("r_op2", 32'(regs_m[d]), 32'(r_op2));
        check_val("rdst_addr", 32'(d), 32'(rdst_addr));
      end
    end
    for (int s = 0; s < `REG_CNT; s++) begin
      next_cycle();
      instr = reg_instr(decode_pkg::OP_NOT, 3'(s), 3'(7 - s));   // rdst field ignored
      #1;
      check_val("op1", 32'(regs_m[s]), 32'(op1));
      check_val("r_op2", 32'(regs_m[s]), 32'(r_op2));
    end
    report("register read and writeback", err_start);

    // ##################################################
    // decode table
    // ##################################################
    err_start = errors;
    for (int o = 0; o <= int'(decode_pkg::OP_CALL); o++) begin
      op   = decode_pkg::opcode_e'(o);
      word = lcg_next();
      next_cycle();
      instr = {op, word[10:0]};
      #1;
      check_val("ctrl", 32'(expected_ctrl(op)), 32'(ctrl));
      check_val("branch", 32'(o >= int'(decode_pkg::OP_JZ) && o <= int'(decode_pkg::OP_JMP)),
                32'(branch));
      check_val("shift_amount", 32'(word[7:0]), 32'(shift_amount));
      check_val("i_op2", 32'({op, word[10:0]}), 32'(i_op2));
      check_val("rsrc_addr", 32'(word[10:8]), 32'(rsrc_addr));
    end
    report("decode table", err_start);

    // ##################################################
    // jump resolution
    // ##################################################
    err_start = errors;
    for (int j = 0; j < 4; j++) begin
      for (int f = 0; f < 8; f++) begin
        op   = decode_pkg::opcode_e'(int'(decode_pkg::OP_JZ) + j);
        word = lcg_next();
        next_cycle();
        instr = reg_instr(op, word[2:0], word[5:3]);
        ccr   = 3'(f);
        #1;
        exp_taken = (j == 3) || (j == 0 && ccr[0]) || (j == 1 && ccr[1]) ||
                    (j == 2 && ccr[2]);
        exp_sel   = exp_taken ? decode_pkg::PC_JUMP : decode_pkg::PC_SEQ;
        check_val("branch", 32'd1, 32'(branch));
        check_val("branch_taken", 32'(exp_taken), 32'(branch_taken));
        check_val("pc_sel", 32'(exp_sel), 32'(pc_sel));
        if (exp_taken) begin
          check_val("pc_jmp", {16'h0, regs_m[word[5:3]]}, pc_jmp);
        end
      end
    end
    next_cycle();
    instr = '0;
    ccr   = '0;
    report("jump resolution", err_start);

    // ##################################################
    // ret and rti sequences
    // ##################################################
    err_start = errors;
    for (int t = 0; t < 2; t++) begin
      op  = (t == 0) ? decode_pkg::OP_RET : decode_pkg::OP_RTI;
      len = (t == 0) ? `RET_CYCLES : `RTI_CYCLES;
      for (int k = 0; k <= len; k++) begin
        next_cycle();
        instr = reg_instr((k == 0) ? op : decode_pkg::OP_NOP, 3'd0, 3'd0);
        #1;
        exp         = expected_ctrl((k == 0) ? op : decode_pkg::OP_NOP);
        exp.stack   = (k < len - 1);
        exp.mem_rd  = (k < len - 1);
        exp.pop_ccr = (k < len - 3);
        exp.pop_pc1 = (k == len - 3);
        exp.pop_pc2 = (k == len - 2);
        exp_sel     = (k == len - 1) ? decode_pkg::PC_STACK : decode_pkg::PC_SEQ;
        check_val("ctrl", 32'(exp), 32'(ctrl));
        check_val("pc_sel", 32'(exp_sel), 32'(pc_sel));
        check_val("freeze", 32'(k < len - 1), 32'(freeze));
        check_val("fetch_pc_enable", 32'(k >= len - 1), 32'(fetch_pc_enable));
      end
    end
    report("ret and rti sequences", err_start);

    // ##################################################
    // interrupt entry
    // ##################################################
    err_start = errors;
    next_cycle();
    interrupt = 1'b1;
    for (int k = 0; k <= `INT_CYCLES; k++) begin
      next_cycle();
      interrupt = 1'b0;
      #1;
      exp              = expected_ctrl(decode_pkg::OP_NOP);
      exp.stack        = (k < `INT_CYCLES);
      exp.mem_wr       = (k < `INT_CYCLES);
      exp.mem_data_sel = (k == 0) ? decode_pkg::MEM_PC :
                         (k == 1) ? decode_pkg::MEM_CCR : decode_pkg::MEM_REG;
      exp_sel          = (k == `INT_CYCLES - 1) ? decode_pkg::PC_VECTOR : decode_pkg::PC_SEQ;
      check_val("ctrl", 32'(exp), 32'(ctrl));
      check_val("pc_sel", 32'(exp_sel), 32'(pc_sel));
      check_val("freeze", 32'(k == 0), 32'(freeze));
      check_val("fetch_pc_enable", 32'(k != 0), 32'(fetch_pc_enable));
    end
    report("interrupt entry", err_start);

    // ##################################################
    // load-use bubble
    // ##################################################
    err_start = errors;
    for (int t = 0; t < 3; t++) begin
      op = (t == 0) ? decode_pkg::OP_STD : (t == 1) ? decode_pkg::OP_PUSH : decode_pkg::OP_ADD;
      next_cycle();
      instr    = reg_instr(op, 3'd1, 3'd2);
      load_use = 1'b1;
      #1;
      exp = expected_ctrl(op);
      check_val("strobes", 32'd0, 32'(strobes));
      check_val("ctrl.alu_op", 32'(exp.alu_op), 32'(ctrl.alu_op));
      check_val("fetch_pc_enable", 32'd0, 32'(fetch_pc_enable));
    end
    next_cycle();
    load_use = 1'b0;    // add still held on instr
    #1;
    check_val("ctrl", 32'(expected_ctrl(decode_pkg::OP_ADD)), 32'(ctrl));
    check_val("fetch_pc_enable", 32'd1, 32'(fetch_pc_enable));
    report("load-use bubble", err_start);

    next_cycle();
    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src/branch_unit.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module branch_unit (
  input  logic               branch,
  input  logic [1:0]         jump_type,
  input  logic [2:0]         ccr,       // {c, n, z}
  input  logic [`DATA_W-1:0] target,
  output logic               taken,
  output logic [`PC_W-1:0]   pc_jmp
);

  logic cond;

  always_comb begin
    case (jump_type)
      2'd0:    cond = ccr[0];   // jz
      2'd1:    cond = ccr[1];   // jn
      2'd2:    cond = ccr[2];   // jc
      default: cond = 1'b1;     // jmp
    endcase
  end

  assign taken = branch & cond;

  // target register value becomes the new pc
  assign pc_jmp = {{(`PC_W - `DATA_W){1'b0}}, target};

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  decode_pkg::opcode_e opcode,
  input  logic                load_use,
  input  logic                interrupt,
  input  logic                branch_taken,
  output decode_pkg::ctrl_t   ctrl,
  output logic                branch,
  output decode_pkg::pc_sel_e pc_sel,
  output logic                freeze,
  output logic                fetch_pc_enable
);

  typedef enum logic [2:0] {
    IDLE, POP_CCR, POP_PC1, POP_PC2, RESUME, INT_PC, INT_CCR
  } seq_e;

  seq_e              state_q;
  seq_e              state_cur;   // state seen by this cycle's outputs
  seq_e              state_nx;
  decode_pkg::ctrl_t seq_ctrl;
  logic [4:0]        op_bits;

  function automatic decode_pkg::ctrl_t decode_op(input decode_pkg::opcode_e op);
    decode_pkg::ctrl_t c;
    c = '0;
    case (op)
      decode_pkg::OP_ADD: c.alu_op = decode_pkg::ALU_ADD;
      decode_pkg::OP_SUB: c.alu_op = decode_pkg::ALU_SUB;
      decode_pkg::OP_AND: c.alu_op = decode_pkg::ALU_AND;
      decode_pkg::OP_OR:  c.alu_op = decode_pkg::ALU_OR;
      decode_pkg::OP_NOT: c.alu_op = decode_pkg::ALU_NOT;
      decode_pkg::OP_INC: c.alu_op = decode_pkg::ALU_INC;
      decode_pkg::OP_SHL: c.alu_op = decode_pkg::ALU_SHL;
      decode_pkg::OP_SHR: c.alu_op = decode_pkg::ALU_SHR;
      default:            c.alu_op = decode_pkg::ALU_PASS;
    endcase
    case (op)
      decode_pkg::OP_ADD, decode_pkg::OP_SUB, decode_pkg::OP_AND, decode_pkg::OP_OR: begin
        c.reg_wr = 1'b1;
      end
      decode_pkg::OP_NOT, decode_pkg::OP_INC, decode_pkg::OP_POP, decode_pkg::OP_IN: begin
        c.alu_src = 2'b01;
        c.reg_wr  = 1'b1;
      end
      decode_pkg::OP_SHL, decode_pkg::OP_SHR, decode_pkg::OP_LDM: begin
        c.alu_src = 2'b11;
        c.reg_wr  = 1'b1;
      end
      decode_pkg::OP_LDD: begin
        c.mem_rd = 1'b1;
        c.reg_wr = 1'b1;
      end
      decode_pkg::OP_STD: c.mem_wr = 1'b1;
      decode_pkg::OP_PUSH, decode_pkg::OP_OUT: c.alu_src = 2'b01;
      decode_pkg::OP_CALL: begin
        c.call         = 1'b1;
        c.stack        = 1'b1;
        c.mem_wr       = 1'b1;
        c.mem_data_sel = decode_pkg::MEM_PC;   // return address
      end
      decode_pkg::OP_RET: c.ret = 1'b1;
      decode_pkg::OP_RTI: c.rti = 1'b1;
      default: ;
    endcase
    // per-opcode extras on top of the groups above
    c.ldm        = (op == decode_pkg::OP_LDM);
    c.mem_to_reg = (op == decode_pkg::OP_LDD) || (op == decode_pkg::OP_POP);
    c.stack      = c.stack || (op == decode_pkg::OP_PUSH) || (op == decode_pkg::OP_POP);
    c.mem_wr     = c.mem_wr || (op == decode_pkg::OP_PUSH);
    c.mem_rd     = c.mem_rd || (op == decode_pkg::OP_POP);
    c.port_rd    = (op == decode_pkg::OP_IN);
    c.port_wr    = (op == decode_pkg::OP_OUT);
    return c;
  endfunction

  // ##################################################
  // ret / rti / interrupt sequencer
  // ##################################################
  always_comb begin
    state_cur = state_q;
    if (state_q == IDLE && !load_use) begin
      if (opcode == decode_pkg::OP_RET) begin
        state_cur = POP_PC1;
      end else if (opcode == decode_pkg::OP_RTI) begin
        state_cur = POP_CCR;
      end
    end
  end

  always_comb begin
    case (state_cur)
      IDLE:    state_nx = interrupt ? INT_PC : IDLE;   // sampled only between sequences
      POP_CCR: state_nx = POP_PC1;
      POP_PC1: state_nx = POP_PC2;
      POP_PC2: state_nx = RESUME;
      INT_PC:  state_nx = INT_CCR;
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else if (!load_use) begin
      state_q <= state_nx;
    end
  end

  // ##################################################
  // outputs
  // ##################################################
  assign op_bits = opcode;
  assign branch  = (op_bits[4:2] == 3'b100) && (state_cur == IDLE) && !load_use;

  always_comb begin
    // held instruction is ignored once a sequence is under way
    seq_ctrl = (state_q == IDLE) ? decode_op(opcode) : decode_op(decode_pkg::OP_NOP);
    pc_sel   = decode_pkg::PC_SEQ;
    case (state_cur)
      IDLE: begin
        if (branch_taken || (opcode == decode_pkg::OP_CALL && !load_use)) begin
          pc_sel = decode_pkg::PC_JUMP;
        end
      end
      POP_CCR, POP_PC1, POP_PC2: begin
        seq_ctrl.stack   = 1'b1;
        seq_ctrl.mem_rd  = 1'b1;
        seq_ctrl.pop_ccr = (state_cur == POP_CCR);
        seq_ctrl.pop_pc1 = (state_cur == POP_PC1);
        seq_ctrl.pop_pc2 = (state_cur == POP_PC2);
      end
      RESUME: pc_sel = decode_pkg::PC_STACK;
      INT_PC, INT_CCR: begin
        seq_ctrl.stack        = 1'b1;
        seq_ctrl.mem_wr       = 1'b1;
        seq_ctrl.mem_data_sel = (state_cur == INT_PC) ? decode_pkg::MEM_PC : decode_pkg::MEM_CCR;
        if (state_cur == INT_CCR) begin
          pc_sel = decode_pkg::PC_VECTOR;
        end
      end
      default: ;
    endcase
    ctrl = seq_ctrl;
    if (load_use) begin                         // bubble keeps only the operand selects
      ctrl              = '0;
      ctrl.alu_op       = seq_ctrl.alu_op;
      ctrl.alu_src      = seq_ctrl.alu_src;
      ctrl.mem_data_sel = seq_ctrl.mem_data_sel;
    end
  end

  assign freeze          = (state_cur == POP_CCR) || (state_cur == POP_PC1) ||
                           (state_cur == POP_PC2) || (state_cur == INT_PC);
  assign fetch_pc_enable = !freeze && !load_use;

endmodule

// File: src/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// ##################################################
// datapath sizes
// ##################################################
`define DATA_W 16          // data and instruction word
`define REG_CNT 8          // register file depth
`define PC_W 32            // program counter width

// ##################################################
// interrupt and return sequences
// ##################################################
`define INT_VECTOR 32'h0000_0010   // isr entry pc
`define RET_CYCLES 3
`define RTI_CYCLES 4               // ret plus the ccr pop
`define INT_CYCLES 2

`endif

// File: src/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

  typedef logic [$clog2(`REG_CNT)-1:0] reg_addr_t;

  typedef enum logic [4:0] {
    OP_NOP, OP_ADD, OP_SUB, OP_AND,
    OP_OR, OP_NOT, OP_INC, OP_SHL,
    OP_SHR, OP_LDM, OP_LDD, OP_STD,
    OP_PUSH, OP_POP, OP_IN, OP_OUT,
    OP_JZ, OP_JN, OP_JC, OP_JMP,       // low two bits pick the flag
    OP_CALL, OP_RET, OP_RTI
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_NOT, ALU_INC, ALU_SHL, ALU_SHR
  } alu_op_e;

  typedef enum logic [1:0] {PC_SEQ, PC_JUMP, PC_STACK, PC_VECTOR} pc_sel_e;

  typedef enum logic [1:0] {MEM_REG, MEM_PC, MEM_CCR} mem_sel_e;

  // ##################################################
  // instruction word, two views
  // ##################################################
  typedef struct packed {
    opcode_e    opcode;
    reg_addr_t  rsrc;
    reg_addr_t  rdst;
    logic [4:0] unused;
  } reg_form_t;

  typedef struct packed {
    opcode_e    opcode;
    reg_addr_t  rsrc;
    logic [7:0] imm8;      // shift amount or immediate
  } imm_form_t;

  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } instr_u;

  // ##################################################
  // downstream control and writeback
  // ##################################################
  typedef struct packed {
    alu_op_e    alu_op;
    logic [1:0] alu_src;   // bit 0 single operand, bit 1 immediate
    logic       reg_wr;
    logic       mem_rd;
    logic       mem_wr;
    logic       mem_to_reg;
    logic       ldm;
    logic       stack;
    logic       port_rd;
    logic       port_wr;
    logic       call;
    logic       ret;
    logic       rti;
    logic       pop_pc1;
    logic       pop_pc2;
    logic       pop_ccr;
    mem_sel_e   mem_data_sel;
  } ctrl_t;

  typedef struct packed {
    logic               wr_en;
    reg_addr_t          addr;
    logic [`DATA_W-1:0] data;
  } wb_t;

endpackage

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`DATA_W-1:0]    instr,
  input  decode_pkg::wb_t       wb,
  input  logic                  load_use,
  input  logic                  interrupt,
  input  logic [2:0]            ccr,
  output decode_pkg::ctrl_t     ctrl,
  output logic                  branch,
  output logic                  branch_taken,
  output decode_pkg::pc_sel_e   pc_sel,
  output logic [`PC_W-1:0]      pc_jmp,
  output logic [`DATA_W-1:0]    op1,
  output logic [`DATA_W-1:0]    r_op2,
  output logic [`DATA_W-1:0]    i_op2,
  output logic [7:0]            shift_amount,
  output decode_pkg::reg_addr_t rdst_addr,
  output decode_pkg::reg_addr_t rsrc_addr,
  output logic                  freeze,
  output logic                  fetch_pc_enable
);

  decode_pkg::instr_u    ins;
  decode_pkg::reg_addr_t rd_addr2;
  logic [4:0]            op_bits;

  assign ins     = instr;
  assign op_bits = ins.reg_form.opcode;

  // single-operand forms read rsrc on both ports
  assign rd_addr2 = ctrl.alu_src[0] ? ins.reg_form.rsrc : ins.reg_form.rdst;

  reg_file i_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb       (wb),
    .rd_addr1 (ins.reg_form.rsrc),
    .rd_addr2 (rd_addr2),
    .rd_data1 (op1),
    .rd_data2 (r_op2)
  );

  control_unit i_control_unit (
    .clk             (clk),
    .rst_n           (rst_n),
    .opcode          (ins.reg_form.opcode),
    .load_use        (load_use),
    .interrupt       (interrupt),
    .branch_taken    (branch_taken),
    .ctrl            (ctrl),
    .branch          (branch),
    .pc_sel          (pc_sel),
    .freeze          (freeze),
    .fetch_pc_enable (fetch_pc_enable)
  );

  branch_unit i_branch_unit (
    .branch    (branch),
    .jump_type (op_bits[1:0]),
    .ccr       (ccr),
    .target    (r_op2),          // rdst value
    .taken     (branch_taken),
    .pc_jmp    (pc_jmp)
  );

  assign i_op2        = instr;
  assign shift_amount = ins.imm_form.imm8;
  assign rdst_addr    = rd_addr2;
  assign rsrc_addr    = ins.reg_form.rsrc;

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  decode_pkg::wb_t       wb,
  input  decode_pkg::reg_addr_t rd_addr1,
  input  decode_pkg::reg_addr_t rd_addr2,
  output logic [`DATA_W-1:0]    rd_data1,
  output logic [`DATA_W-1:0]    rd_data2
);

  logic [`DATA_W-1:0] regs [`REG_CNT];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wr_en) begin
      regs[wb.addr] <= wb.data;     // new value seen after the edge
    end
  end

  // no write bypass
  assign rd_data1 = regs[rd_addr1];
  assign rd_data2 = regs[rd_addr2];

endmodule
